// ==== hw/bar_pkg.sv ====
package bar_pkg;

    localparam int BAR_ADDR_W   = 16;
    localparam int BAR_OFFSET_W = 11;
    localparam int BAR_WORD_W   = 32;
    localparam int DMA_ADDR_W   = 64;
    localparam int XFER_LEN_W   = 16;
    // length as seen on the dma side ports
    localparam int PORT_LEN_W   = 11;

    typedef logic [BAR_ADDR_W-1:0]   bar_addr_t;
    typedef logic [BAR_OFFSET_W-1:0] bar_offset_t;
    typedef logic [BAR_WORD_W-1:0]   bar_word_t;
    typedef logic [DMA_ADDR_W-1:0]   dma_addr_t;
    typedef logic [XFER_LEN_W-1:0]   xfer_len_t;

    // space taken from host address bits 15:13
    typedef enum logic [2:0] {
        SPACE_CTRL  = 3'b000,
        SPACE_TOD   = 3'b001,
        SPACE_M6XUP = 3'b010,
        SPACE_M6XDN = 3'b011
    } space_sel_t;

    localparam bar_offset_t TEST1              = 11'h000;
    localparam bar_offset_t TEST2              = 11'h004;
    localparam bar_offset_t PCIE_RST           = 11'h008;
    localparam bar_offset_t FPGA_VER           = 11'h010;
    localparam bar_offset_t CLR_DMA_SET        = 11'h014;
    localparam bar_offset_t DMA_WRLEN          = 11'h01C;
    localparam bar_offset_t DMA_RDLEN          = 11'h024;
    localparam bar_offset_t DMA_START          = 11'h028;
    localparam bar_offset_t CLR_DMA_FLAG       = 11'h02C;
    localparam bar_offset_t ETHUP_BYTE_CNT     = 11'h030;
    localparam bar_offset_t ETHUP_BYTE_CNT_CLR = 11'h034;
    localparam bar_offset_t DMAWR_ADD_LO       = 11'h038;
    localparam bar_offset_t DMAWR_ADD_HI       = 11'h03C;
    localparam bar_offset_t DMARD_ADD_LO       = 11'h040;
    localparam bar_offset_t DMARD_ADD_HI       = 11'h044;
    localparam bar_offset_t MSI_MASK           = 11'h048;

    localparam bar_word_t  TEST1_INIT = 32'hAAAA_AAAA;
    localparam bar_word_t  TEST2_INIT = 32'h5555_5555;
    // {uart_rx, pps1, pulse, eth}
    localparam logic [3:0] MASK_INIT  = 4'b1000;

    typedef struct packed {
        logic        valid;
        bar_offset_t offset;
        bar_word_t   data;
    } bar_wr_cmd_t;

    typedef struct packed {
        bar_word_t   test1;
        bar_word_t   test2;
        dma_addr_t   wr_base;
        dma_addr_t   rd_base;
        bar_word_t   rd_len;
        logic [3:0]  msi_mask;
        logic        wr_start;
        logic        rd_start;
        logic        clr_eth;
        logic        pcie_rst;
    } ctrl_view_t;

    typedef struct packed {
        logic        wrdone;
        logic        rddone;
        xfer_len_t   up_len;
    } dma_status_t;

    localparam ctrl_view_t CTRL_DEFAULT = '{
        test1    : TEST1_INIT,
        test2    : TEST2_INIT,
        wr_base  : '0,
        rd_base  : '0,
        rd_len   : '0,
        msi_mask : MASK_INIT,
        wr_start : 1'b0,
        rd_start : 1'b0,
        clr_eth  : 1'b0,
        pcie_rst : 1'b0
    };

endpackage

// ==== hw/bar_access_decode.sv ====
`timescale 1ns/1ps

module bar_access_decode
    import bar_pkg::*;
(
    input  logic        user_clk,
    input  logic        user_reset,
    input  bar_addr_t   wr_io_add,
    input  bar_word_t   wr_io_dat,
    input  logic        wr_io_en,
    input  logic        rd_req,
    input  bar_addr_t   rd_add,
    output bar_wr_cmd_t wr_cmd,
    output bar_offset_t rd_offset,
    output logic        rd_ctrl_hit
);

    bar_addr_t  wr_add_r;
    bar_word_t  wr_dat_r;
    logic [1:0] wr_en_r;
    logic       wr_edge;
    space_sel_t wr_space;

    bar_addr_t  rd_add_r;
    logic [2:0] rd_req_r;
    logic       rd_edge;
    space_sel_t rd_space;

    // host holds address and data while the enable is high
    always_ff @(posedge user_clk) begin
        wr_add_r <= wr_io_add;
        wr_dat_r <= wr_io_dat;
        rd_add_r <= rd_add;
    end

    always_ff @(posedge user_clk) begin
        if (user_reset) begin
            wr_en_r  <= 2'b00;
            rd_req_r <= 3'b000;
        end else begin
            wr_en_r  <= {wr_en_r[0], wr_io_en};
            rd_req_r <= {rd_req_r[1:0], rd_req};
        end
    end

    assign wr_edge  = wr_en_r[0] & ~wr_en_r[1];
    assign rd_edge  = rd_req_r[1] & ~rd_req_r[2];
    assign wr_space = space_sel_t'(wr_add_r[15:13]);
    assign rd_space = space_sel_t'(rd_add_r[15:13]);

    // one command per enable edge in the control space
    always_ff @(posedge user_clk) begin
        if (user_reset) begin
            wr_cmd.valid <= 1'b0;
        end else begin
            wr_cmd.valid <= wr_edge && (wr_space == SPACE_CTRL);
        end
        wr_cmd.offset <= wr_add_r[10:0];
        wr_cmd.data   <= wr_dat_r;
    end

    // held until the next request edge
    always_ff @(posedge user_clk) begin
        if (user_reset) begin
            rd_offset   <= '0;
            rd_ctrl_hit <= 1'b0;
        end else if (rd_edge) begin
            rd_offset   <= rd_add_r[10:0];
            rd_ctrl_hit <= (rd_space == SPACE_CTRL);
        end
    end

    a_single_wr_cmd : assert property (
        @(posedge user_clk) disable iff (user_reset)
        wr_cmd.valid |=> !wr_cmd.valid
    );

endmodule

// ==== hw/bar_control_regs.sv ====
`timescale 1ns/1ps

module bar_control_regs
    import bar_pkg::*;
(
    input  logic        user_clk,
    input  logic        user_reset,
    input  bar_wr_cmd_t wr_cmd,
    output ctrl_view_t  view,
    output logic [1:0]  clr_done,
    output logic        clr_eth,
    output logic        dma_wr_start,
    output logic        dma_rd_start,
    output logic        pcie_reset
);

    ctrl_view_t regs;
    logic       clr_settings;
    logic [1:0] clr_set_d;
    logic       soft_clr;
    logic [3:0] pcie_rst_d;
    logic       start_both;

    // soft clear fires on the rising edge of the settings bit
    always_ff @(posedge user_clk) begin
        if (user_reset) begin
            clr_set_d <= 2'b00;
        end else begin
            clr_set_d <= {clr_set_d[0], clr_settings};
        end
    end

    assign soft_clr = clr_set_d[0] & ~clr_set_d[1];

    // bits 0 and 8 together start nothing
    assign start_both = wr_cmd.data[0] & wr_cmd.data[8];

    always_ff @(posedge user_clk) begin
        if (user_reset || soft_clr) begin
            regs         <= CTRL_DEFAULT;
            clr_settings <= 1'b0;
            clr_done     <= 2'b00;
        end else begin
            // start and done-clear only live for one cycle
            regs.wr_start <= 1'b0;
            regs.rd_start <= 1'b0;
            clr_done      <= 2'b00;
            if (wr_cmd.valid) begin
                case (wr_cmd.offset)
                    TEST1: begin
                        regs.test1 <= wr_cmd.data;
                    end
                    TEST2: begin
                        regs.test2 <= wr_cmd.data;
                    end
                    PCIE_RST: begin
                        regs.pcie_rst <= wr_cmd.data[0];
                    end
                    CLR_DMA_SET: begin
                        clr_settings <= wr_cmd.data[0];
                    end
                    DMAWR_ADD_LO: begin
                        regs.wr_base[31:0] <= wr_cmd.data;
                    end
                    DMAWR_ADD_HI: begin
                        regs.wr_base[63:32] <= wr_cmd.data;
                    end
                    DMARD_ADD_LO: begin
                        regs.rd_base[31:0] <= wr_cmd.data;
                    end
                    DMARD_ADD_HI: begin
                        regs.rd_base[63:32] <= wr_cmd.data;
                    end
                    DMA_RDLEN: begin
                        regs.rd_len <= wr_cmd.data;
                    end
                    DMA_START: begin
                        if (!start_both) begin
                            regs.wr_start <= wr_cmd.data[0];
                            regs.rd_start <= wr_cmd.data[8];
                        end
                    end
                    CLR_DMA_FLAG: begin
                        clr_done <= {wr_cmd.data[8], wr_cmd.data[0]};
                    end
                    ETHUP_BYTE_CNT_CLR: begin
                        regs.clr_eth <= wr_cmd.data[0];
                    end
                    MSI_MASK: begin
                        regs.msi_mask <= wr_cmd.data[3:0];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // pcie reset fires once the bit has fallen through the delay line
    always_ff @(posedge user_clk) begin
        if (user_reset) begin
            pcie_rst_d <= 4'b0000;
        end else begin
            pcie_rst_d <= {pcie_rst_d[2:0], regs.pcie_rst};
        end
    end

    assign pcie_reset   = pcie_rst_d[3] & ~pcie_rst_d[2];

    assign view         = regs;
    assign clr_eth      = regs.clr_eth;
    assign dma_wr_start = regs.wr_start;
    assign dma_rd_start = regs.rd_start;

    a_start_exclusive : assert property (
        @(posedge user_clk) disable iff (user_reset)
        !(dma_wr_start && dma_rd_start)
    );

endmodule

// ==== hw/dma_status_track.sv ====
`timescale 1ns/1ps

module dma_status_track
    import bar_pkg::*;
(
    input  logic                  user_clk,
    input  logic                  user_reset,
    input  logic                  dma_wrdone,
    input  logic                  dma_rddone,
    input  logic [1:0]            clr_done,
    input  logic                  clr_eth,
    input  logic                  upstream_start,
    input  logic [PORT_LEN_W-1:0] upstream_len,
    output dma_status_t           status
);

    // index 0 is write-done, 1 is read-done
    logic [2:0][1:0] done_sync;
    logic [1:0]      done_set;
    logic [1:0]      done_flag;

    // eth clear rides along as bit 2
    logic [1:0][2:0] clr_sr;
    logic [2:0]      clr_p;

    logic [3:0]      start_d;
    xfer_len_t       len_d1;
    xfer_len_t       len_d2;
    xfer_len_t       up_len;

    always_ff @(posedge user_clk) begin
        if (user_reset) begin
            done_sync <= '0;
            clr_sr    <= '0;
            start_d   <= 4'b0000;
        end else begin
            done_sync <= {done_sync[1:0], {dma_rddone, dma_wrdone}};
            clr_sr    <= {clr_sr[0], {clr_eth, clr_done}};
            start_d   <= {start_d[2:0], upstream_start};
        end
    end

    assign done_set = done_sync[1] & ~done_sync[2];
    assign clr_p    = clr_sr[0] & ~clr_sr[1];

    // sticky flags where a clear wins over a same-cycle set
    always_ff @(posedge user_clk) begin
        if (user_reset) begin
            done_flag <= 2'b11;
        end else begin
            done_flag <= (done_flag | done_set) & ~clr_p[1:0];
        end
    end

    always_ff @(posedge user_clk) begin
        len_d1 <= xfer_len_t'(upstream_len);
        len_d2 <= len_d1;
    end

    always_ff @(posedge user_clk) begin
        if (user_reset) begin
            up_len <= '0;
        end else if (start_d[2] & ~start_d[3]) begin
            up_len <= len_d2;
        end else if (clr_p[2]) begin
            up_len <= '0;
        end
    end

    assign status.wrdone = done_flag[0];
    assign status.rddone = done_flag[1];
    assign status.up_len = up_len;

endmodule

// ==== hw/bar_readback.sv ====
`timescale 1ns/1ps

module bar_readback
    import bar_pkg::*;
#(
    parameter logic [15:0] FPGA_VER_HI = 16'h0000,
    parameter logic [15:0] FPGA_VER_LO = 16'h0001
) (
    input  logic        user_clk,
    input  logic        user_reset,
    input  bar_offset_t rd_offset,
    input  logic        rd_ctrl_hit,
    input  ctrl_view_t  view,
    input  dma_status_t status,
    output bar_word_t   rd_dat
);

    bar_word_t rd_dat_r;
    bar_word_t sel_word;

    always_comb begin
        sel_word = '0;
        if (rd_ctrl_hit) begin
            case (rd_offset)
                TEST1:              sel_word = ~view.test1;
                TEST2:              sel_word = ~view.test2;
                PCIE_RST:           sel_word = {31'h0, view.pcie_rst};
                FPGA_VER:           sel_word = {FPGA_VER_HI, FPGA_VER_LO};
                DMAWR_ADD_LO:       sel_word = view.wr_base[31:0];
                DMAWR_ADD_HI:       sel_word = view.wr_base[63:32];
                DMARD_ADD_LO:       sel_word = view.rd_base[31:0];
                DMARD_ADD_HI:       sel_word = view.rd_base[63:32];
                // length and length plus header
                DMA_WRLEN:          sel_word = {status.up_len, status.up_len + 16'd16};
                DMA_RDLEN:          sel_word = view.rd_len;
                DMA_START:          sel_word = {23'h0, view.rd_start, 7'h0, view.wr_start};
                CLR_DMA_FLAG:       sel_word = {23'h0, status.rddone, 7'h0, status.wrdone};
                ETHUP_BYTE_CNT:     sel_word = {16'h0, status.up_len};
                ETHUP_BYTE_CNT_CLR: sel_word = {31'h0, view.clr_eth};
                MSI_MASK:           sel_word = {28'h0, view.msi_mask};
                default:            sel_word = '0;
            endcase
        end
    end

    // re-registered every cycle so reads track register changes
    always_ff @(posedge user_clk) begin
        if (user_reset) begin
            rd_dat_r <= '0;
        end else begin
            rd_dat_r <= sel_word;
        end
    end

    // host sees the word byte-reversed
    assign rd_dat = {rd_dat_r[7:0], rd_dat_r[15:8], rd_dat_r[23:16], rd_dat_r[31:24]};

endmodule

// ==== hw/bar_space_top.sv ====
`timescale 1ns/1ps

module bar_space_top
    import bar_pkg::*;
#(
    parameter logic [15:0] FPGA_VER_HI = 16'h0000,
    parameter logic [15:0] FPGA_VER_LO = 16'h0001
) (
    input  logic                  user_clk,
    input  logic                  user_reset,
    input  bar_addr_t             wr_io_add,
    input  bar_word_t             wr_io_dat,
    input  logic                  wr_io_en,
    input  logic                  rd_req,
    input  bar_addr_t             rd_add,
    output bar_word_t             rd_dat,
    input  logic                  upstream_start,
    input  logic [PORT_LEN_W-1:0] upstream_len,
    output logic [PORT_LEN_W-1:0] downstream_len,
    output dma_addr_t             dma_wr_base,
    output dma_addr_t             dma_rd_base,
    output logic                  dma_wr_start,
    output logic                  dma_rd_start,
    input  logic                  dma_wrdone,
    input  logic                  dma_rddone,
    output logic                  dma_upstream_flag,
    output logic                  pulse_int_mask,
    output logic                  eth_int_mask,
    output logic                  pps1_mask,
    output logic                  m6x_uart_rx_mask,
    output logic                  pcie_reset
);

    bar_wr_cmd_t wr_cmd;
    bar_offset_t rd_offset;
    logic        rd_ctrl_hit;
    ctrl_view_t  view;
    dma_status_t status;
    logic [1:0]  clr_done;
    logic        clr_eth;

    bar_access_decode u_decode (
        .user_clk    (user_clk),
        .user_reset  (user_reset),
        .wr_io_add   (wr_io_add),
        .wr_io_dat   (wr_io_dat),
        .wr_io_en    (wr_io_en),
        .rd_req      (rd_req),
        .rd_add      (rd_add),
        .wr_cmd      (wr_cmd),
        .rd_offset   (rd_offset),
        .rd_ctrl_hit (rd_ctrl_hit)
    );

    bar_control_regs u_ctrl (
        .user_clk     (user_clk),
        .user_reset   (user_reset),
        .wr_cmd       (wr_cmd),
        .view         (view),
        .clr_done     (clr_done),
        .clr_eth      (clr_eth),
        .dma_wr_start (dma_wr_start),
        .dma_rd_start (dma_rd_start),
        .pcie_reset   (pcie_reset)
    );

    dma_status_track u_status (
        .user_clk       (user_clk),
        .user_reset     (user_reset),
        .dma_wrdone     (dma_wrdone),
        .dma_rddone     (dma_rddone),
        .clr_done       (clr_done),
        .clr_eth        (clr_eth),
        .upstream_start (upstream_start),
        .upstream_len   (upstream_len),
        .status         (status)
    );

    bar_readback #(
        .FPGA_VER_HI (FPGA_VER_HI),
        .FPGA_VER_LO (FPGA_VER_LO)
    ) u_readback (
        .user_clk    (user_clk),
        .user_reset  (user_reset),
        .rd_offset   (rd_offset),
        .rd_ctrl_hit (rd_ctrl_hit),
        .view        (view),
        .status      (status),
        .rd_dat      (rd_dat)
    );

    assign downstream_len    = view.rd_len[PORT_LEN_W-1:0];
    assign dma_wr_base       = view.wr_base;
    assign dma_rd_base       = view.rd_base;
    assign dma_upstream_flag = status.wrdone;

    // mask bits are {uart_rx, pps1, pulse, eth}
    assign m6x_uart_rx_mask  = view.msi_mask[3];
    assign pps1_mask         = view.msi_mask[2];
    assign pulse_int_mask    = view.msi_mask[1];
    assign eth_int_mask      = view.msi_mask[0];

endmodule

// ==== bench/tb_bar_space.sv ====
`timescale 1ns/1ps

module tb_bar_space
    import bar_pkg::*;
();

    localparam string CASE_FILE    = "bench/bar_cases.txt";
    localparam int    RESET_CYCLES = 16;

    logic                  user_clk = 1'b0;
    logic                  user_reset;
    bar_addr_t             wr_io_add;
    bar_word_t             wr_io_dat;
    logic                  wr_io_en;
    logic                  rd_req;
    bar_addr_t             rd_add;
    bar_word_t             rd_dat;
    logic                  upstream_start;
    logic [PORT_LEN_W-1:0] upstream_len;
    logic [PORT_LEN_W-1:0] downstream_len;
    dma_addr_t             dma_wr_base;
    dma_addr_t             dma_rd_base;
    logic                  dma_wr_start;
    logic                  dma_rd_start;
    logic                  dma_wrdone;
    logic                  dma_rddone;
    logic                  dma_upstream_flag;
    logic                  pulse_int_mask;
    logic                  eth_int_mask;
    logic                  pps1_mask;
    logic                  m6x_uart_rx_mask;
    logic                  pcie_reset;

    int checks_done     = 0;
    int wd_cycles       = 0;
    int wr_start_seen   = 0;
    int rd_start_seen   = 0;
    int pcie_reset_seen = 0;
    int wr_start_base   = 0;
    int rd_start_base   = 0;
    int pcie_reset_base = 0;

    bar_space_top #(
        .FPGA_VER_HI (16'h1234),
        .FPGA_VER_LO (16'h5678)
    ) i_bar_space_top (
        .user_clk          (user_clk),
        .user_reset        (user_reset),
        .wr_io_add         (wr_io_add),
        .wr_io_dat         (wr_io_dat),
        .wr_io_en          (wr_io_en),
        .rd_req            (rd_req),
        .rd_add            (rd_add),
        .rd_dat            (rd_dat),
        .upstream_start    (upstream_start),
        .upstream_len      (upstream_len),
        .downstream_len    (downstream_len),
        .dma_wr_base       (dma_wr_base),
        .dma_rd_base       (dma_rd_base),
        .dma_wr_start      (dma_wr_start),
        .dma_rd_start      (dma_rd_start),
        .dma_wrdone        (dma_wrdone),
        .dma_rddone        (dma_rddone),
        .dma_upstream_flag (dma_upstream_flag),
        .pulse_int_mask    (pulse_int_mask),
        .eth_int_mask      (eth_int_mask),
        .pps1_mask         (pps1_mask),
        .m6x_uart_rx_mask  (m6x_uart_rx_mask),
        .pcie_reset        (pcie_reset)
    );

    always #20 user_clk = ~user_clk;

    // pulse outputs counted between rising edges
    always @(negedge user_clk) begin
        if (!user_reset) begin
            if (dma_wr_start) begin
                wr_start_seen = wr_start_seen + 1;
            end
            if (dma_rd_start) begin
                rd_start_seen = rd_start_seen + 1;
            end
            if (pcie_reset) begin
                pcie_reset_seen = pcie_reset_seen + 1;
            end
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
        checks_done++;
        assert (got === exp) else begin
            abort_run($sformatf("[ERROR] t=%0t %s expected %h got %h", $time, name, exp, got));
        end
    endtask

    task automatic check_fields(input int got, input int want, input string op);
        if (got != want) begin
            abort_run($sformatf("case file line for %s has %0d fields, needs %0d", op, got, want));
        end
    endtask

    task automatic write_reg(input bar_addr_t addr, input bar_word_t data);
        wr_io_add = addr;
        wr_io_dat = data;
        wr_io_en  = 1'b1;
        repeat (3) @(negedge user_clk);
        wr_io_en = 1'b0;
        repeat (3) @(negedge user_clk);
    endtask

    task automatic read_reg(input bar_addr_t addr, input bar_word_t exp);
        rd_add = addr;
        rd_req = 1'b1;
        repeat (6) @(negedge user_clk);
        check_value($sformatf("rd_dat[%h]", addr), 64'(exp), 64'(rd_dat));
        rd_req = 1'b0;
        repeat (3) @(negedge user_clk);
    endtask

    task automatic pulse_input(input string name, input int cycles,
                               input logic [PORT_LEN_W-1:0] len);
        if (name == "wrdone") begin
            dma_wrdone = 1'b1;
        end else if (name == "rddone") begin
            dma_rddone = 1'b1;
        end else if (name == "upstart") begin
            upstream_len   = len;
            upstream_start = 1'b1;
        end else begin
            abort_run($sformatf("case file names an unknown input: %s", name));
        end
        repeat (cycles) @(negedge user_clk);
        dma_wrdone     = 1'b0;
        dma_rddone     = 1'b0;
        upstream_start = 1'b0;
        repeat (2) @(negedge user_clk);
    endtask

    task automatic check_port(input string name, input logic [63:0] exp);
        if (name == "wr_start" || name == "rd_start" || name == "pcie_reset") begin
            repeat (10) @(negedge user_clk);
            // counters settle between falling edges
            @(posedge user_clk);
            if (name == "wr_start") begin
                check_value("dma_wr_start count", exp, 64'(wr_start_seen - wr_start_base));
                wr_start_base = wr_start_seen;
            end else if (name == "rd_start") begin
                check_value("dma_rd_start count", exp, 64'(rd_start_seen - rd_start_base));
                rd_start_base = rd_start_seen;
            end else begin
                check_value("pcie_reset count", exp, 64'(pcie_reset_seen - pcie_reset_base));
                pcie_reset_base = pcie_reset_seen;
            end
            @(negedge user_clk);
        end else begin
            repeat (8) @(negedge user_clk);
            if (name == "wr_base") begin
                check_value("dma_wr_base", exp, dma_wr_base);
            end else if (name == "rd_base") begin
                check_value("dma_rd_base", exp, dma_rd_base);
            end else if (name == "dn_len") begin
                check_value("downstream_len", exp, 64'(downstream_len));
            end else if (name == "upflag") begin
                check_value("dma_upstream_flag", exp, 64'(dma_upstream_flag));
            end else if (name == "mask") begin
                check_value("mask outputs", exp, 64'({m6x_uart_rx_mask, pps1_mask,
                                                      pulse_int_mask, eth_int_mask}));
            end else begin
                abort_run($sformatf("case file names an unknown output: %s", name));
            end
        end
    endtask

    // budget grows with the length of the case file
    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge user_clk);
        abort_run($sformatf("timeout: case file not done after %0d cycles", wd_cycles));
    end

    initial begin
        int                    fd;
        int                    n;
        int                    lines;
        int                    cycles;
        string                 op;
        string                 name;
        logic [8*128-1:0]      line_buf;
        bar_addr_t             addr;
        bar_word_t             data;
        logic [63:0]           exp;
        logic [PORT_LEN_W-1:0] len;

        user_reset     = 1'b1;
        wr_io_add      = '0;
        wr_io_dat      = '0;
        wr_io_en       = 1'b0;
        rd_req         = 1'b0;
        rd_add         = '0;
        upstream_start = 1'b0;
        upstream_len   = '0;
        dma_wrdone     = 1'b0;
        dma_rddone     = 1'b0;
        lines          = 0;

        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            abort_run($sformatf("cannot open case file %s", CASE_FILE));
        end
        while ($fgets(line_buf, fd) != 0) begin
            lines++;
        end
        $fclose(fd);
        wd_cycles = lines * 20;

        repeat (RESET_CYCLES) @(posedge user_clk);
        @(negedge user_clk);
        user_reset = 1'b0;
        repeat (2) @(negedge user_clk);

        fd = $fopen(CASE_FILE, "r");
        while ($fscanf(fd, "%s", op) == 1) begin
            if (op == "#") begin
                n = $fgets(line_buf, fd);
            end else if (op == "wr") begin
                n = $fscanf(fd, "%h %h", addr, data);
                check_fields(n, 2, op);
                write_reg(addr, data);
            end else if (op == "rd") begin
                n = $fscanf(fd, "%h %h", addr, data);
                check_fields(n, 2, op);
                read_reg(addr, data);
            end else if (op == "pulse") begin
                n = $fscanf(fd, "%s %d %h", name, cycles, len);
                check_fields(n, 3, op);
                pulse_input(name, cycles, len);
            end else if (op == "port") begin
                n = $fscanf(fd, "%s %h", name, exp);
                check_fields(n, 2, op);
                check_port(name, exp);
            end else begin
                abort_run($sformatf("unknown operation %s in case file", op));
            end
        end
        $fclose(fd);

        if (checks_done > 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            abort_run("no checks were run from the case file");
        end
    end

endmodule

// ==== bench/bar_cases.txt ====
# wr    host_addr  data      host write through the level enable
# rd    host_addr  expected  word as the host sees it, byte-swapped
# pulse input      cycles    upstream_len in hex, used by upstart only
# port  output     expected  wr_start rd_start pcie_reset give the count since their last check
# reset defaults
rd 0000 55555555
rd 0048 08000000
rd 002C 01010000
rd 0010 78563412
port upflag 1
port wr_start 0
port rd_start 0
port pcie_reset 0
# register write and read back
wr 0000 12345678
wr 0038 89ABCDEF
wr 003C 01234567
wr 0040 DEADBEEF
wr 0044 0000CAFE
wr 0024 00000123
wr 0048 00000005
rd 0000 87A9CBED
rd 0038 EFCDAB89
rd 003C 67452301
rd 0024 23010000
rd 0048 05000000
port wr_base 0123456789ABCDEF
port rd_base 0000CAFEDEADBEEF
port dn_len 123
port mask 5
# dma start pulses
wr 0028 00000001
port wr_start 1
port rd_start 0
wr 0028 00000100
port wr_start 0
port rd_start 1
wr 0028 00000101
port wr_start 0
port rd_start 0
# done flags
wr 002C 00000101
rd 002C 00000000
port upflag 0
pulse wrdone 2 000
rd 002C 01000000
port upflag 1
# upstream length
pulse upstart 2 064
rd 0030 64000000
rd 001C 74006400
wr 0034 00000001
rd 0030 00000000
rd 001C 10000000
# soft clear, other space, pcie reset
wr 0014 00000001
rd 0000 55555555
rd 0048 08000000
port wr_base 0
port rd_base 0
port dn_len 0
wr 2000 FFFFFFFF
rd 0000 55555555
rd 2000 00000000
wr 0008 00000001
rd 0008 01000000
wr 0008 00000000
port pcie_reset 1

// ==== list.f ====
hw/bar_pkg.sv
hw/bar_access_decode.sv
hw/bar_control_regs.sv
hw/dma_status_track.sv
hw/bar_readback.sv
hw/bar_space_top.sv
bench/tb_bar_space.sv

// ==== Makefile ====
SIM  = obj_dir/Vtb_bar_space
SRCS = $(wildcard hw/*.sv) $(wildcard bench/*.sv)

.PHONY: all run clean

all: run

$(SIM): list.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_bar_space -f list.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
